// File: muldiv_msg_pkg.sv
// ----------------------------
// request and response message layout
// function codes, widths, payload types
// ----------------------------

`default_nettype none

package muldiv_msg_pkg;

  // ----------------------------
  // function codes
  // ----------------------------

  // fn_mul signed product, fn_div signed divide, fn_divu unsigned divide
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } fn_t;

  // ----------------------------
  // widths
  // ----------------------------

  // one operand word
  localparam int data_width   = 32;
  // one response word, two operand words
  localparam int result_width = 64;

  // ----------------------------
  // payloads
  // ----------------------------

  // request operands a and b
  typedef logic [data_width-1:0] operand_t;

  // response word
  // upper half: remainder or high product
  // lower half: quotient or low product
  typedef logic [result_width-1:0] result_t;

endpackage

`default_nettype wire

// File: muldiv_cfg_pkg.sv
// ----------------------------
// unit configuration: step counts,
// counter type, order queue, unit select
// ----------------------------

`default_nettype none

package muldiv_cfg_pkg;

  // one step per operand bit
  localparam int div_steps = 32;
  localparam int mul_steps = 32;

  // iteration counter, wide enough for either step count
  typedef logic [5:0] count_t;

  // requests in flight at once, one per unit
  localparam int order_depth = 2;

  // which unit owns a queued request
  typedef enum logic [0:0] {
    unit_mul = 1'b0,
    unit_div = 1'b1
  } unit_t;

endpackage

`default_nettype wire

// File: int_div_dpath.sv
// ----------------------------
// divider datapath: operand registers,
// restoring shift-subtract step, sign fix
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module int_div_dpath (
  input  wire                    clk,
  input  wire                    reset,
  input  muldiv_msg_pkg::fn_t    req_fn,
  input  muldiv_msg_pkg::operand_t req_a,
  input  muldiv_msg_pkg::operand_t req_b,
  input  wire                    load,
  input  wire                    a_en,
  input  wire                    b_en,
  input  wire                    a_mux_sel,
  input  wire                    sub_mux_sel,
  output muldiv_msg_pkg::result_t resp_result
);

  // ----------------------------
  // operand capture
  // ----------------------------

  muldiv_msg_pkg::fn_t      fn_reg;
  logic                     sign_a;
  logic                     sign_b;
  muldiv_msg_pkg::operand_t b_reg;
  // {remainder(33), quotient(32)}
  logic [64:0]              a_reg;

  logic                     req_signed;
  muldiv_msg_pkg::operand_t mag_a;
  muldiv_msg_pkg::operand_t mag_b;
  logic [64:0]              a_init;

  // magnitudes only for the signed divide
  assign req_signed = (req_fn == muldiv_msg_pkg::fn_div);
  assign mag_a  = (req_signed && req_a[31]) ? (~req_a + 1'b1) : req_a;
  assign mag_b  = (req_signed && req_b[31]) ? (~req_b + 1'b1) : req_b;
  assign a_init = {33'b0, mag_a};

  // ----------------------------
  // shift-subtract step
  // ----------------------------

  logic [64:0] a_shift;
  logic [64:0] diff;
  logic        take_diff;
  logic [64:0] a_step;

  assign a_shift = a_reg << 1;
  // divisor sits in the upper half
  assign diff    = a_shift - {1'b0, b_reg, 32'b0};
  // keep shifted value when trial goes negative
  assign take_diff = sub_mux_sel && !diff[64];
  assign a_step    = take_diff ? {diff[64:1], 1'b1} : a_shift;

  // fn and sign flags
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg <= muldiv_msg_pkg::fn_divu;
      sign_a <= 1'b0;
      sign_b <= 1'b0;
    end else if (load) begin
      fn_reg <= req_fn;
      sign_a <= req_a[31];
      sign_b <= req_b[31];
    end
  end

  // remainder/quotient and divisor
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_sel ? a_step : a_init;
    end
    if (b_en) begin
      b_reg <= mag_b;
    end
  end

  // ----------------------------
  // sign fix
  // ----------------------------

  logic                     is_signed;
  logic                     b_zero;
  muldiv_msg_pkg::operand_t quot_mag;
  muldiv_msg_pkg::operand_t rem_mag;
  muldiv_msg_pkg::operand_t quot;
  muldiv_msg_pkg::operand_t rem;

  assign is_signed = (fn_reg == muldiv_msg_pkg::fn_div);
  assign b_zero    = (b_reg == '0);
  assign quot_mag  = a_reg[31:0];
  assign rem_mag   = a_reg[63:32];

  // zero divisor ends with quotient all ones and rem = |a|,
  // so the quotient is left alone and the rem fix restores a
  assign quot = (is_signed && (sign_a ^ sign_b) && !b_zero) ? (~quot_mag + 1'b1)
                                                           : quot_mag;
  // remainder takes the dividend's sign
  assign rem  = (is_signed && sign_a) ? (~rem_mag + 1'b1) : rem_mag;

  assign resp_result = {rem, quot};

endmodule

`default_nettype wire

// File: int_div_ctrl.sv
// ----------------------------
// divider control FSM
// idle, calc, done with step counter
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module int_div_ctrl (
  input  wire clk,
  input  wire reset,
  input  wire req_val,
  output wire req_rdy,
  output wire resp_val,
  input  wire resp_rdy,
  output wire load,
  output wire a_en,
  output wire b_en,
  output wire a_mux_sel,
  output wire sub_mux_sel
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_t;

  state_t                 state;
  state_t                 state_next;
  muldiv_cfg_pkg::count_t count;
  logic                   accept;
  logic                   last_step;

  assign accept    = req_val && req_rdy;
  assign last_step = (count == muldiv_cfg_pkg::count_t'(muldiv_cfg_pkg::div_steps - 1));

  // ----------------------------
  // state register and counter
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      state <= state_next;
      if (accept) begin
        count <= '0;
      end else if (state == st_calc) begin
        count <= count + 1'b1;
      end
    end
  end

  // next state
  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (accept) state_next = st_calc;
      end
      st_calc: begin
        // one step per cycle, div_steps in total
        if (last_step) state_next = st_done;
      end
      st_done: begin
        // hold result until the response transfers
        if (resp_rdy) state_next = st_idle;
      end
      default: state_next = st_idle;
    endcase
  end

  // ----------------------------
  // handshake and datapath controls
  // ----------------------------

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  // operand capture on the accept cycle
  assign load = accept;
  assign b_en = accept;
  assign a_en = accept || (state == st_calc);

  // initial value on load, step value in calc
  assign a_mux_sel   = (state == st_calc);
  // subtract path open during calc, sign test lives in the datapath
  assign sub_mux_sel = (state == st_calc);

endmodule

`default_nettype wire

// File: int_mul_iterative.sv
// ----------------------------
// iterative shift-add signed multiplier
// with its own FSM and val/rdy ports
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module int_mul_iterative (
  input  wire                      clk,
  input  wire                      reset,
  input  muldiv_msg_pkg::fn_t      req_fn,
  input  muldiv_msg_pkg::operand_t req_a,
  input  muldiv_msg_pkg::operand_t req_b,
  input  wire                      req_val,
  output wire                      req_rdy,
  output muldiv_msg_pkg::result_t  resp_result,
  output wire                      resp_val,
  input  wire                      resp_rdy
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_t;

  state_t                 state;
  muldiv_cfg_pkg::count_t count;
  logic                   accept;
  logic                   last_step;

  assign accept    = req_val && req_rdy;
  assign last_step = (count == muldiv_cfg_pkg::count_t'(muldiv_cfg_pkg::mul_steps - 1));

  // ----------------------------
  // operand magnitudes
  // ----------------------------

  logic                     req_signed;
  muldiv_msg_pkg::operand_t mag_a;
  muldiv_msg_pkg::operand_t mag_b;

  assign req_signed = (req_fn == muldiv_msg_pkg::fn_mul);
  assign mag_a = (req_signed && req_a[31]) ? (~req_a + 1'b1) : req_a;
  assign mag_b = (req_signed && req_b[31]) ? (~req_b + 1'b1) : req_b;

  // ----------------------------
  // control
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          count <= count + 1'b1;
          if (last_step) state <= st_done;
        end
        st_done: begin
          if (resp_rdy) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------
  // shift-add datapath
  // ----------------------------

  logic                     neg;
  logic [63:0]              mcand;
  muldiv_msg_pkg::operand_t mplier;
  muldiv_msg_pkg::result_t  prod;

  always_ff @(posedge clk) begin
    if (accept) begin
      // product sign from the raw operand signs
      neg    <= req_signed && (req_a[31] ^ req_b[31]);
      mcand  <= {32'b0, mag_a};
      mplier <= mag_b;
      prod   <= '0;
    end else if (state == st_calc) begin
      // add shifted multiplicand on a set multiplier bit
      if (mplier[0]) begin
        prod <= prod + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  // product stays in place until the transfer
  assign resp_result = neg ? (~prod + 1'b1) : prod;

endmodule

`default_nettype wire

// File: muldiv_dispatch.sv
// ----------------------------
// request steering, in-order response
// queue and response multiplexing
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module muldiv_dispatch (
  input  wire                     clk,
  input  wire                     reset,
  input  muldiv_msg_pkg::fn_t     req_fn,
  input  wire                     req_val,
  output wire                     req_rdy,
  output wire                     mul_req_val,
  input  wire                     mul_req_rdy,
  output wire                     div_req_val,
  input  wire                     div_req_rdy,
  input  muldiv_msg_pkg::result_t mul_resp_result,
  input  wire                     mul_resp_val,
  output wire                     mul_resp_rdy,
  input  muldiv_msg_pkg::result_t div_resp_result,
  input  wire                     div_resp_val,
  output wire                     div_resp_rdy,
  output muldiv_msg_pkg::result_t resp_result,
  output wire                     resp_val,
  input  wire                     resp_rdy
);

  // ----------------------------
  // order queue
  // ----------------------------

  muldiv_cfg_pkg::unit_t order_q [muldiv_cfg_pkg::order_depth];

  logic [$clog2(muldiv_cfg_pkg::order_depth)-1:0]   head;
  logic [$clog2(muldiv_cfg_pkg::order_depth)-1:0]   tail;
  logic [$clog2(muldiv_cfg_pkg::order_depth+1)-1:0] count;

  logic                  full;
  logic                  empty;
  logic                  push;
  logic                  pop;
  muldiv_cfg_pkg::unit_t req_unit;
  muldiv_cfg_pkg::unit_t head_unit;

  assign full  = (int'(count) == muldiv_cfg_pkg::order_depth);
  assign empty = (count == '0);

  // ----------------------------
  // request steering
  // ----------------------------

  // both divide functions go to the divider
  assign req_unit = (req_fn == muldiv_msg_pkg::fn_mul) ? muldiv_cfg_pkg::unit_mul
                                                      : muldiv_cfg_pkg::unit_div;

  assign req_rdy = !full && ((req_unit == muldiv_cfg_pkg::unit_mul) ? mul_req_rdy
                                                                    : div_req_rdy);

  // val only reaches the target unit, and never when full
  assign mul_req_val = req_val && !full && (req_unit == muldiv_cfg_pkg::unit_mul);
  assign div_req_val = req_val && !full && (req_unit == muldiv_cfg_pkg::unit_div);

  assign push = req_val && req_rdy;

  // ----------------------------
  // response side
  // ----------------------------

  assign head_unit = order_q[head];

  // only the oldest request's unit may answer
  assign resp_val = !empty && ((head_unit == muldiv_cfg_pkg::unit_mul) ? mul_resp_val
                                                                       : div_resp_val);
  assign resp_result = (head_unit == muldiv_cfg_pkg::unit_mul) ? mul_resp_result
                                                               : div_resp_result;

  assign mul_resp_rdy = resp_rdy && !empty && (head_unit == muldiv_cfg_pkg::unit_mul);
  assign div_resp_rdy = resp_rdy && !empty && (head_unit == muldiv_cfg_pkg::unit_div);

  assign pop = resp_val && resp_rdy;

  // queue storage
  always_ff @(posedge clk) begin
    if (push) begin
      order_q[tail] <= req_unit;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= (int'(tail) == muldiv_cfg_pkg::order_depth - 1) ? '0 : tail + 1'b1;
      end
      if (pop) begin
        head <= (int'(head) == muldiv_cfg_pkg::order_depth - 1) ? '0 : head + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: int_muldiv.sv
// ----------------------------
// multiply/divide unit top level
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module int_muldiv (
  input  wire                      clk,
  input  wire                      reset,
  input  muldiv_msg_pkg::fn_t      req_fn,
  input  muldiv_msg_pkg::operand_t req_a,
  input  muldiv_msg_pkg::operand_t req_b,
  input  wire                      req_val,
  output wire                      req_rdy,
  output muldiv_msg_pkg::result_t  resp_result,
  output wire                      resp_val,
  input  wire                      resp_rdy
);

  // unit handshakes
  wire                     mul_req_val;
  wire                     mul_req_rdy;
  wire                     mul_resp_val;
  wire                     mul_resp_rdy;
  muldiv_msg_pkg::result_t mul_resp_result;
  wire                     div_req_val;
  wire                     div_req_rdy;
  wire                     div_resp_val;
  wire                     div_resp_rdy;
  muldiv_msg_pkg::result_t div_resp_result;

  // divider control to datapath
  wire load;
  wire a_en;
  wire b_en;
  wire a_mux_sel;
  wire sub_mux_sel;

  muldiv_dispatch dispatch (
    .clk             (clk),
    .reset           (reset),
    .req_fn          (req_fn),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .mul_req_val     (mul_req_val),
    .mul_req_rdy     (mul_req_rdy),
    .div_req_val     (div_req_val),
    .div_req_rdy     (div_req_rdy),
    .mul_resp_result (mul_resp_result),
    .mul_resp_val    (mul_resp_val),
    .mul_resp_rdy    (mul_resp_rdy),
    .div_resp_result (div_resp_result),
    .div_resp_val    (div_resp_val),
    .div_resp_rdy    (div_resp_rdy),
    .resp_result     (resp_result),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy)
  );

  // operands go straight to both units
  int_mul_iterative mul (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy)
  );

  int_div_ctrl div_ctrl (
    .clk         (clk),
    .reset       (reset),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .load        (load),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_mux_sel   (a_mux_sel),
    .sub_mux_sel (sub_mux_sel)
  );

  int_div_dpath div_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .load        (load),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_mux_sel   (a_mux_sel),
    .sub_mux_sel (sub_mux_sel),
    .resp_result (div_resp_result)
  );

endmodule

`default_nettype wire

// File: int_muldiv_checker.sv
// ----------------------------
// handshake assertions, bound into int_muldiv
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module int_muldiv_checker (
  input wire                     clk,
  input wire                     reset,
  input wire                     req_val,
  input wire                     req_rdy,
  input wire                     resp_val,
  input wire                     resp_rdy,
  input muldiv_msg_pkg::result_t resp_result
);

  // requests accepted but not yet answered, mirrors the order queue
  int in_flight;
  int failures = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(req_val && req_rdy) - int'(resp_val && resp_rdy);
    end
  end

  // stalled response stays put
  hold_resp: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else begin
      $error("response dropped or changed while resp_rdy was low");
      failures = failures + 1;
    end

  // no request accepted with the queue full
  full_blocks_req: assert property (@(posedge clk) disable iff (reset)
    (in_flight == muldiv_cfg_pkg::order_depth) |-> !req_rdy)
    else begin
      $error("req_rdy high while the order queue is full");
      failures = failures + 1;
    end

  reset_clears_resp: assert property (@(posedge clk) reset |=> !resp_val)
    else begin
      $error("resp_val high in the cycle after reset");
      failures = failures + 1;
    end

endmodule

bind int_muldiv int_muldiv_checker checker_inst (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

`default_nettype wire

// File: tb_int_muldiv.sv
// ----------------------------
// testbench for the multiply/divide unit
// stimulus, reference model, compare, watchdog
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_int_muldiv;

  localparam int num_directed = 18;
  localparam int num_random   = 60;
  localparam int num_stall    = 40;
  // 40 cycles per request, plus room for stalled responses
  localparam int watchdog_cycles = (num_directed + num_random + num_stall) * 40
                                   + num_stall * 40 + 400;

  logic                     clk;
  logic                     reset;
  muldiv_msg_pkg::fn_t      req_fn;
  muldiv_msg_pkg::operand_t req_a;
  muldiv_msg_pkg::operand_t req_b;
  logic                     req_val;
  wire                      req_rdy;
  muldiv_msg_pkg::result_t  resp_result;
  wire                      resp_val;
  logic                     resp_rdy;

  // resp_rdy mode, 0 always ready, 1 held low, 2 random
  int                       rdy_mode;
  string                    test_name;
  int                       sent_count;
  int                       resp_count;
  muldiv_msg_pkg::result_t  expected_q [$];
  string                    name_q [$];

  int_muldiv int_muldiv_inst (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #20 clk = ~clk;

  // ----------------------------
  // reference model
  // ----------------------------

  function automatic muldiv_msg_pkg::result_t ref_result(
    muldiv_msg_pkg::fn_t fn, muldiv_msg_pkg::operand_t a, muldiv_msg_pkg::operand_t b);
    longint                   sa;
    longint                   sb;
    muldiv_msg_pkg::operand_t quot;
    muldiv_msg_pkg::operand_t rem;
    muldiv_msg_pkg::result_t  res;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (fn == muldiv_msg_pkg::fn_mul) begin
      // full 64-bit signed product
      res = sa * sb;
    end else begin
      if (b == '0) begin
        // zero divisor gives all ones and the dividend back
        quot = '1;
        rem  = a;
      end else if (fn == muldiv_msg_pkg::fn_div) begin
        // truncating divide, remainder takes the dividend's sign
        quot = 32'(sa / sb);
        rem  = 32'(sa % sb);
      end else begin
        quot = a / b;
        rem  = a % b;
      end
      res = {rem, quot};
    end
    return res;
  endfunction

  // extremes and small values show up often
  function automatic muldiv_msg_pkg::operand_t random_operand();
    muldiv_msg_pkg::operand_t val;
    int                       sel;
    sel = $urandom_range(0, 7);
    case (sel)
      0:       val = 32'h8000_0000;
      1:       val = 32'h7fff_ffff;
      2:       val = 32'hffff_ffff;
      3:       val = 32'($urandom_range(0, 15));
      default: val = $urandom;
    endcase
    return val;
  endfunction

  function automatic muldiv_msg_pkg::fn_t random_fn();
    return muldiv_msg_pkg::fn_t'($urandom_range(0, 2));
  endfunction

  // ----------------------------
  // compare tasks
  // ----------------------------

  task automatic compare_result(string name, muldiv_msg_pkg::result_t expected,
                                muldiv_msg_pkg::result_t actual);
    if (actual !== expected) begin
      $display("error %s expected %h actual %h", name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic compare_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("error %s expected %b actual %b", name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // ----------------------------
  // drivers
  // ----------------------------

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // hold the request until an edge with rdy high
  task automatic send_req(muldiv_msg_pkg::fn_t fn, muldiv_msg_pkg::operand_t a,
                          muldiv_msg_pkg::operand_t b);
    logic accepted;
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    req_val  = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = req_rdy;
      next_cycle();
    end
    req_val = 1'b0;
  endtask

  task automatic wait_drain();
    @(posedge clk);
    while (resp_count != sent_count) begin
      @(posedge clk);
    end
    #2;
  endtask

  always @(posedge clk) begin
    #2;
    case (rdy_mode)
      0:       resp_rdy = 1'b1;
      1:       resp_rdy = 1'b0;
      default: resp_rdy = ($urandom_range(0, 2) == 0);
    endcase
  end

  // expected result recorded at each request transfer
  always @(negedge clk) begin
    if (!reset && req_val && req_rdy) begin
      expected_q.push_back(ref_result(req_fn, req_a, req_b));
      name_q.push_back(test_name);
      sent_count++;
    end
  end

  // one expected result per response transfer, oldest first
  always @(negedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      if (expected_q.size() == 0) begin
        $display("a response arrived with no request outstanding");
        $display("Testbench failed");
        $fatal(1, "unexpected response");
      end else begin
        compare_result(name_q.pop_front(), expected_q.pop_front(), resp_result);
        resp_count++;
      end
    end
  end

  // a handshake assertion that fired in the bound checker
  always @(negedge clk) begin
    if (int_muldiv_inst.checker_inst.failures != 0) begin
      $display("a handshake assertion failed in the bound checker");
      $display("Testbench failed");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout, responses stopped arriving (%0d of %0d received)",
             resp_count, sent_count);
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  // ----------------------------
  // test sequence
  // ----------------------------

  initial begin
    void'($urandom(93));
    clk        = 1'b0;
    reset      = 1'b1;
    req_fn     = muldiv_msg_pkg::fn_mul;
    req_a      = '0;
    req_b      = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b1;
    rdy_mode   = 0;
    sent_count = 0;
    resp_count = 0;
    test_name  = "reset";
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    compare_bit("req_rdy after reset", 1'b1, req_rdy);
    compare_bit("resp_val after reset", 1'b0, resp_val);
    next_cycle();

    test_name = "mul extremes";
    send_req(muldiv_msg_pkg::fn_mul, 32'h8000_0000, 32'h8000_0000);
    send_req(muldiv_msg_pkg::fn_mul, 32'h7fff_ffff, 32'h7fff_ffff);
    send_req(muldiv_msg_pkg::fn_mul, 32'h8000_0000, 32'h7fff_ffff);
    send_req(muldiv_msg_pkg::fn_mul, 32'hffff_ffff, 32'hffff_ffff);
    send_req(muldiv_msg_pkg::fn_mul, 32'hffff_fff9, 32'd6);
    send_req(muldiv_msg_pkg::fn_mul, 32'd0, 32'h8000_0000);
    test_name = "div signs";
    send_req(muldiv_msg_pkg::fn_div, 32'hffff_fff9, 32'd2);
    send_req(muldiv_msg_pkg::fn_div, 32'd7, 32'hffff_fffe);
    send_req(muldiv_msg_pkg::fn_div, 32'hffff_fff9, 32'hffff_fffe);
    test_name = "div min by minus one";
    send_req(muldiv_msg_pkg::fn_div, 32'h8000_0000, 32'hffff_ffff);
    test_name = "divu";
    send_req(muldiv_msg_pkg::fn_divu, 32'hffff_ffff, 32'd7);
    send_req(muldiv_msg_pkg::fn_divu, 32'h8000_0000, 32'hffff_ffff);
    test_name = "divide by zero";
    send_req(muldiv_msg_pkg::fn_div, 32'hffff_fffb, 32'd0);
    send_req(muldiv_msg_pkg::fn_div, 32'h8000_0000, 32'd0);
    send_req(muldiv_msg_pkg::fn_divu, 32'hdead_beef, 32'd0);
    send_req(muldiv_msg_pkg::fn_divu, 32'd0, 32'd0);
    wait_drain();

    // both units finish while the response side is stalled
    test_name = "divide then multiply";
    rdy_mode  = 1;
    send_req(muldiv_msg_pkg::fn_div, 32'd1000, 32'd7);
    send_req(muldiv_msg_pkg::fn_mul, 32'd1234, 32'hffff_d000);
    repeat (40) @(posedge clk);
    @(negedge clk);
    compare_bit("resp_val with both done", 1'b1, resp_val);
    compare_bit("req_rdy with queue full", 1'b0, req_rdy);
    next_cycle();
    rdy_mode = 0;
    wait_drain();

    test_name = "random";
    for (int i = 0; i < num_random; i++) begin
      send_req(random_fn(), random_operand(), random_operand());
    end
    wait_drain();

    test_name = "random with stalls";
    rdy_mode  = 2;
    for (int i = 0; i < num_stall; i++) begin
      send_req(random_fn(), random_operand(), random_operand());
    end
    wait_drain();
    rdy_mode = 0;

    if (resp_count == sent_count && expected_q.size() == 0
        && int_muldiv_inst.checker_inst.failures == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("%0d requests, %0d responses, %0d assertion failures",
               sent_count, resp_count, int_muldiv_inst.checker_inst.failures);
      $display("Testbench failed");
      $fatal(1, "run ended with errors");
    end
  end

endmodule

`default_nettype wire

// File: all.f
muldiv_msg_pkg.sv
muldiv_cfg_pkg.sv
int_div_dpath.sv
int_div_ctrl.sv
int_mul_iterative.sv
muldiv_dispatch.sv
int_muldiv.sv
int_muldiv_checker.sv
tb_int_muldiv.sv

// File: Makefile
# Verilator build and run for the multiply/divide unit

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_int_muldiv
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Testbench passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
